// File: qla_pkg.sv
package qla_pkg;

    // --------------------
    // bus geometry
    // --------------------
    localparam int NUM_AXES = 4;
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int CUR_W = 16;
    localparam int BOARD_ID_W = 4;

    // address split, channel in bits 7:4, offset in bits 3:0
    localparam int CHAN_LSB = 4;
    localparam int CHAN_W = 4;
    localparam int OFF_W = 4;

    // channel number, 0 is the board block
    typedef logic [CHAN_W-1:0] axis_sel_t;
    localparam axis_sel_t BOARD_CHAN = '0;

    // --------------------
    // register offsets
    // --------------------
    // axis block
    localparam logic [OFF_W-1:0] OFF_DAC_CMD = 4'd0;
    localparam logic [OFF_W-1:0] OFF_ADC_FB = 4'd1;
    localparam logic [OFF_W-1:0] OFF_SAFETY = 4'd2;
    // board block
    localparam logic [OFF_W-1:0] OFF_BOARD_CTRL = 4'd0;
    localparam logic [OFF_W-1:0] OFF_BOARD_ID = 4'd1;

    // safety check, trip on this many over-limit samples in a row
    localparam int SAFETY_COUNT = 4;
    localparam int CNT_W = $clog2(SAFETY_COUNT + 1);
    // safety read word: trip flag here, count in the low bits
    localparam int SAFE_TRIP_BIT = 31;

    // read strobe to read valid, in cycles
    localparam int READ_LATENCY = 2;

    // --------------------
    // register word
    // --------------------
    // one 32-bit word, seen either as a current or as board control
    typedef union packed {
        struct packed {
            logic [15:0]             unused;
            logic signed [CUR_W-1:0] cur;
        } dac;
        struct packed {
            logic [15:0]         rsvd_hi;
            logic [NUM_AXES-1:0] trip;      // read only
            logic [NUM_AXES-1:0] amp_en;    // read only
            logic [NUM_AXES-1:0] amp_mask;
            logic [2:0]          rsvd_lo;
            logic                pwr_en;
        } ctrl;
    } reg_word_t;

endpackage

// File: reg_bus_if.sv
`timescale 1ns/1ns

// decoded register traffic, decoder to the register blocks
interface reg_bus_if import qla_pkg::*; ();

    // write side
    logic             wr_stb;
    axis_sel_t        wr_chan;
    logic [OFF_W-1:0] wr_off;
    reg_word_t        wr_data;

    // read side, data returns on the blocks' own rdata paths
    logic             rd_stb;
    axis_sel_t        rd_chan;
    logic [OFF_W-1:0] rd_off;

    // decoder side
    modport src (
        output wr_stb, wr_chan, wr_off, wr_data,
        output rd_stb, rd_chan, rd_off
    );

    // register block side
    modport dst (
        input wr_stb, wr_chan, wr_off, wr_data,
        input rd_stb, rd_chan, rd_off
    );

endinterface

// File: reg_decoder.sv
`timescale 1ns/1ns

module reg_decoder import qla_pkg::*; (
    input  logic              sysclk,
    input  logic              rst_n,
    // host write
    input  logic              reg_wen,
    input  logic [ADDR_W-1:0] reg_waddr,
    input  logic [DATA_W-1:0] reg_wdata,
    // host read
    input  logic              reg_ren,
    input  logic [ADDR_W-1:0] reg_raddr,
    // decoded bus
    reg_bus_if.src            bus
);

    // --------------------
    // address split
    // --------------------
    axis_sel_t        wr_chan_in;
    logic [OFF_W-1:0] wr_off_in;
    axis_sel_t        rd_chan_in;
    logic [OFF_W-1:0] rd_off_in;

    // channel field sits right above the offset
    assign wr_chan_in = reg_waddr[CHAN_LSB +: CHAN_W];
    assign wr_off_in  = reg_waddr[OFF_W-1:0];
    assign rd_chan_in = reg_raddr[CHAN_LSB +: CHAN_W];
    assign rd_off_in  = reg_raddr[OFF_W-1:0];

    // --------------------
    // strobes
    // --------------------
    // one cycle from host strobe to bus strobe
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            bus.wr_stb <= 1'b0;
            bus.rd_stb <= 1'b0;
        end else begin
            bus.wr_stb <= reg_wen;
            bus.rd_stb <= reg_ren;
        end
    end

    // --------------------
    // address and data
    // --------------------
    // captured with the strobe, only meaningful while it is high
    always_ff @(posedge sysclk) begin
        bus.wr_chan <= wr_chan_in;
        bus.wr_off  <= wr_off_in;
        // raw word, each block picks its own view
        bus.wr_data <= reg_wdata;
    end

    // unmapped channels pass through as well
    // nobody claims them, so their reads come back as zero
    always_ff @(posedge sysclk) begin
        bus.rd_chan <= rd_chan_in;
        bus.rd_off  <= rd_off_in;
    end

endmodule

// File: axis_channel.sv
`timescale 1ns/1ns

module axis_channel import qla_pkg::*; #(
    // channel number on the bus, 1 and up
    parameter int unsigned AXIS_ID = 1
) (
    input  logic                    sysclk,
    input  logic                    rst_n,
    reg_bus_if.dst                  bus,
    // current feedback from the adc
    input  logic signed [CUR_W-1:0] cur_fb,
    input  logic                    adc_valid,
    // current command to the dac
    output logic signed [CUR_W-1:0] cur_cmd,
    output logic                    trip,
    output reg_word_t               rdata
);

    logic                    wr_hit;
    logic                    rd_hit;
    logic signed [CUR_W-1:0] fb_q;
    logic [CNT_W-1:0]        cnt_q;
    logic signed [CUR_W:0]   fb_ext;
    logic signed [CUR_W:0]   cmd_ext;
    logic [CUR_W:0]          fb_mag;
    logic [CUR_W:0]          cmd_mag;
    logic [CUR_W+1:0]        cmd_lim;
    logic                    over_lim;
    logic [CNT_W-1:0]        cnt_nxt;
    reg_word_t               rd_word;

    // only our own channel
    assign wr_hit = bus.wr_stb && (bus.wr_chan == CHAN_W'(AXIS_ID));
    assign rd_hit = bus.rd_stb && (bus.rd_chan == CHAN_W'(AXIS_ID));

    // --------------------
    // command register
    // --------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            cur_cmd <= '0;
        end else if (wr_hit && (bus.wr_off == OFF_DAC_CMD)) begin
            cur_cmd <= bus.wr_data.dac.cur;
        end
    end

    // --------------------
    // over-current test
    // --------------------
    // one extra bit so that -32768 has a magnitude
    assign fb_ext  = cur_fb;
    assign cmd_ext = cur_cmd;
    assign fb_mag  = fb_ext[CUR_W] ? -fb_ext : fb_ext;
    assign cmd_mag = cmd_ext[CUR_W] ? -cmd_ext : cmd_ext;
    // twice the command, one more bit again
    assign cmd_lim = {cmd_mag, 1'b0};
    assign over_lim = ({1'b0, fb_mag} > cmd_lim);

    // run length of over-limit samples, holds at SAFETY_COUNT
    always_comb begin
        cnt_nxt = '0;
        if (over_lim) begin
            if (cnt_q < CNT_W'(SAFETY_COUNT)) begin
                cnt_nxt = cnt_q + 1'b1;
            end else begin
                cnt_nxt = cnt_q;
            end
        end
    end

    // sample, counter and trip latch
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            fb_q  <= '0;
            cnt_q <= '0;
            trip  <= 1'b0;
        end else begin
            if (adc_valid) begin
                fb_q <= cur_fb;
            end
            // any safety write rearms the axis, wins over a sample
            if (wr_hit && (bus.wr_off == OFF_SAFETY)) begin
                cnt_q <= '0;
                trip  <= 1'b0;
            end else if (adc_valid) begin
                cnt_q <= cnt_nxt;
                if (cnt_nxt == CNT_W'(SAFETY_COUNT)) begin
                    trip <= 1'b1;
                end
            end
        end
    end

    // --------------------
    // read data
    // --------------------
    always_comb begin
        rd_word = '0;
        case (bus.rd_off)
            OFF_DAC_CMD: rd_word.dac.cur = cur_cmd;
            OFF_ADC_FB:  rd_word.dac.cur = fb_q;
            OFF_SAFETY: begin
                rd_word[SAFE_TRIP_BIT] = trip;
                rd_word[CNT_W-1:0]     = cnt_q;
            end
            default:     rd_word = '0;
        endcase
    end

    // zero unless addressed, so the top can simply OR all blocks
    always_ff @(posedge sysclk) begin
        rdata <= rd_hit ? rd_word : '0;
    end

endmodule

// File: board_regs.sv
`timescale 1ns/1ns

module board_regs import qla_pkg::*; (
    input  logic                       sysclk,
    input  logic                       rst_n,
    reg_bus_if.dst                     bus,
    input  logic [BOARD_ID_W-1:0]      board_id,
    // per-axis trip latches and read words
    input  logic [NUM_AXES-1:0]        axis_trip,
    input  reg_word_t [NUM_AXES-1:0]   axis_rdata,
    // amplifier control
    output logic [NUM_AXES-1:0]        amp_enable,
    output logic                       pwr_enable,
    // host read return
    output logic [DATA_W-1:0]          reg_rdata,
    output logic                       reg_rvalid
);

    logic                      ctrl_wr;
    logic                      rd_hit;
    logic [NUM_AXES-1:0]       mask_q;
    logic [NUM_AXES-1:0]       mask_nxt;
    logic                      pwr_nxt;
    logic [READ_LATENCY-2:0]   rd_pipe;
    reg_word_t                 status_word;
    reg_word_t                 id_word;
    reg_word_t                 own_rdata;
    reg_word_t                 merged;

    assign ctrl_wr = bus.wr_stb && (bus.wr_chan == BOARD_CHAN) &&
                     (bus.wr_off == OFF_BOARD_CTRL);
    assign rd_hit  = bus.rd_stb && (bus.rd_chan == BOARD_CHAN);

    // --------------------
    // control register
    // --------------------
    // next values feed amp_enable too, so both move on the same edge
    always_comb begin
        mask_nxt = mask_q;
        pwr_nxt  = pwr_enable;
        if (ctrl_wr) begin
            mask_nxt = bus.wr_data.ctrl.amp_mask;
            pwr_nxt  = bus.wr_data.ctrl.pwr_en;
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            mask_q     <= '0;
            pwr_enable <= 1'b0;
            amp_enable <= '0;
        end else begin
            mask_q     <= mask_nxt;
            pwr_enable <= pwr_nxt;
            // tripped axes stay off until their trip is cleared
            amp_enable <= mask_nxt & {NUM_AXES{pwr_nxt}} & ~axis_trip;
        end
    end

    // --------------------
    // read side
    // --------------------
    always_comb begin
        status_word               = '0;
        status_word.ctrl.trip     = axis_trip;
        status_word.ctrl.amp_en   = amp_enable;
        status_word.ctrl.amp_mask = mask_q;
        status_word.ctrl.pwr_en   = pwr_enable;
    end

    // id in the low bits
    always_comb begin
        id_word                   = '0;
        id_word[BOARD_ID_W-1:0]   = board_id;
    end

    always_ff @(posedge sysclk) begin
        if (rd_hit && (bus.rd_off == OFF_BOARD_CTRL)) begin
            own_rdata <= status_word;
        end else if (rd_hit && (bus.rd_off == OFF_BOARD_ID)) begin
            own_rdata <= id_word;
        end else begin
            own_rdata <= '0;
        end
    end

    // all other words are zero unless addressed
    always_comb begin
        merged = own_rdata;
        for (int i = 0; i < NUM_AXES; i++) begin
            merged = merged | axis_rdata[i];
        end
    end
    assign reg_rdata = merged;

    // decoder stage is the first cycle of the latency, this is the rest
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            rd_pipe <= '0;
        end else begin
            rd_pipe[0] <= bus.rd_stb;
            for (int i = 1; i < READ_LATENCY - 1; i++) begin
                rd_pipe[i] <= rd_pipe[i-1];
            end
        end
    end
    assign reg_rvalid = rd_pipe[READ_LATENCY-2];

endmodule

// File: motor_ctrl_top.sv
`timescale 1ns/1ns

module motor_ctrl_top import qla_pkg::*; (
    input  logic                               sysclk,
    input  logic                               rst_n,
    // host register bus
    input  logic                               reg_wen,
    input  logic [ADDR_W-1:0]                  reg_waddr,
    input  logic [DATA_W-1:0]                  reg_wdata,
    input  logic                               reg_ren,
    input  logic [ADDR_W-1:0]                  reg_raddr,
    output logic [DATA_W-1:0]                  reg_rdata,
    output logic                               reg_rvalid,
    // current feedback, all axes sampled together
    input  logic signed [NUM_AXES-1:0][CUR_W-1:0] cur_fb,
    input  logic                               adc_valid,
    // amplifier side
    output logic [NUM_AXES-1:0][CUR_W-1:0]     cur_cmd,
    output logic [NUM_AXES-1:0]                amp_enable,
    output logic                               pwr_enable,
    // strapped board number
    input  logic [BOARD_ID_W-1:0]              board_id
);

    // --------------------
    // local wires
    // --------------------
    logic [NUM_AXES-1:0]      axis_trip;
    reg_word_t [NUM_AXES-1:0] axis_rdata;

    // decoded bus shared by all blocks
    reg_bus_if bus ();

    // --------------------
    // host decoder
    // --------------------
    reg_decoder reg_decoder_inst (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .reg_wen   (reg_wen),
        .reg_waddr (reg_waddr),
        .reg_wdata (reg_wdata),
        .reg_ren   (reg_ren),
        .reg_raddr (reg_raddr),
        .bus       (bus)
    );

    // --------------------
    // axes
    // --------------------
    // array slot i answers on channel i+1
    for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
        axis_channel #(
            .AXIS_ID (axis_sel_t'(i + 1))
        ) axis_channel_inst (
            .sysclk    (sysclk),
            .rst_n     (rst_n),
            .bus       (bus),
            .cur_fb    (cur_fb[i]),
            .adc_valid (adc_valid),
            .cur_cmd   (cur_cmd[i]),
            .trip      (axis_trip[i]),
            .rdata     (axis_rdata[i])
        );
    end

    // --------------------
    // board block, channel 0
    // --------------------
    // also merges the axis read words onto the host bus
    board_regs board_regs_inst (
        .sysclk     (sysclk),
        .rst_n      (rst_n),
        .bus        (bus),
        .board_id   (board_id),
        .axis_trip  (axis_trip),
        .axis_rdata (axis_rdata),
        .amp_enable (amp_enable),
        .pwr_enable (pwr_enable),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid)
    );

endmodule

// File: tb_clkgen.sv
`timescale 1ns/1ns

// free running testbench clock
module tb_clkgen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    // starts low, first rising edge half a period in
    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// File: motor_ctrl_tb.sv
`timescale 1ns/1ns

module motor_ctrl_tb import qla_pkg::*; ();

    // well above the length of the whole run
    localparam int TIMEOUT_CYCLES = 4000;
    localparam logic [BOARD_ID_W-1:0] BOARD_ID = 4'hb;

    logic                           sysclk;
    logic                           rst_n;
    logic                           reg_wen;
    logic [ADDR_W-1:0]              reg_waddr;
    logic [DATA_W-1:0]              reg_wdata;
    logic                           reg_ren;
    logic [ADDR_W-1:0]              reg_raddr;
    logic [DATA_W-1:0]              reg_rdata;
    logic                           reg_rvalid;
    logic [NUM_AXES-1:0][CUR_W-1:0] cur_fb;
    logic                           adc_valid;
    logic [NUM_AXES-1:0][CUR_W-1:0] cur_cmd;
    logic [NUM_AXES-1:0]            amp_enable;
    logic                           pwr_enable;
    logic [BOARD_ID_W-1:0]          board_id;

    // scoreboard with one entry per axis
    logic signed [CUR_W-1:0] m_cmd [NUM_AXES];
    logic signed [CUR_W-1:0] m_fb [NUM_AXES];
    logic signed [CUR_W-1:0] next_fb [NUM_AXES];
    int                      m_cnt [NUM_AXES];
    logic [NUM_AXES-1:0]     m_trip;
    logic [NUM_AXES-1:0]     m_mask;
    logic                    m_pwr;
    // outstanding reads with their expected words and issue cycles
    reg_word_t               exp_q [$];
    int                      issue_q [$];
    integer                  seed;
    int                      cyc;
    int                      settle_until;
    logic                    checking;

    tb_clkgen #(.PERIOD_NS(40)) clk_inst (.clk(sysclk));

    motor_ctrl_top motor_ctrl_top_inst (.*);

    // --------------------
    // reference model
    // --------------------
    // feedback magnitude above twice the command magnitude
    function automatic logic over_limit(int fb, int cmd);
        int fb_abs;
        int cmd_abs;
        fb_abs  = (fb < 0) ? -fb : fb;
        cmd_abs = (cmd < 0) ? -cmd : cmd;
        return fb_abs > 2 * cmd_abs;
    endfunction

    function automatic logic [NUM_AXES-1:0] expect_amp();
        return m_mask & {NUM_AXES{m_pwr}} & ~m_trip;
    endfunction

    // word a read of this address should return
    function automatic reg_word_t expect_word(logic [ADDR_W-1:0] addr);
        reg_word_t w;
        int        chan;
        int        off;
        w    = '0;
        chan = addr[CHAN_LSB +: CHAN_W];
        off  = addr[OFF_W-1:0];
        if (chan == 0 && off == OFF_BOARD_CTRL) begin
            w.ctrl.trip     = m_trip;
            w.ctrl.amp_en   = expect_amp();
            w.ctrl.amp_mask = m_mask;
            w.ctrl.pwr_en   = m_pwr;
        end else if (chan == 0 && off == OFF_BOARD_ID) begin
            w[BOARD_ID_W-1:0] = board_id;
        end else if (chan >= 1 && chan <= NUM_AXES) begin
            if (off == OFF_DAC_CMD) begin
                w.dac.cur = m_cmd[chan-1];
            end else if (off == OFF_ADC_FB) begin
                w.dac.cur = m_fb[chan-1];
            end else if (off == OFF_SAFETY) begin
                w[SAFE_TRIP_BIT] = m_trip[chan-1];
                w[CNT_W-1:0]     = CNT_W'(m_cnt[chan-1]);
            end
        end
        return w;
    endfunction

    function automatic logic [ADDR_W-1:0] reg_addr(int chan, int off);
        return ADDR_W'((chan << CHAN_LSB) | off);
    endfunction

    // mostly full range and sometimes kept inside the limit
    function automatic logic signed [CUR_W-1:0] random_fb(int cmd);
        int r;
        int lim;
        r   = $random(seed);
        lim = 2 * ((cmd < 0) ? -cmd : cmd);
        if (r[1:0] != 2'b00) begin
            return CUR_W'($random(seed));
        end else begin
            return CUR_W'($random(seed) % (lim + 1));
        end
    endfunction

    // --------------------
    // checks
    // --------------------
    task automatic fail_now(string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_word(string name, reg_word_t act, reg_word_t exp);
        if (act !== exp) begin
            fail_now($sformatf("FAILED t=%0t %s expected=%h actual=%h", $time, name, exp, act));
        end
    endtask

    task automatic compare_cur(string name, logic signed [CUR_W-1:0] act,
                               logic signed [CUR_W-1:0] exp);
        if (act !== exp) begin
            fail_now($sformatf("FAILED t=%0t %s expected=%0d actual=%0d", $time, name, exp, act));
        end
    endtask

    task automatic compare_enable(logic [NUM_AXES-1:0] amp_act, logic [NUM_AXES-1:0] amp_exp,
                                  logic pwr_act, logic pwr_exp);
        if (amp_act !== amp_exp) begin
            fail_now($sformatf("FAILED t=%0t amp_enable expected=%b actual=%b",
                               $time, amp_exp, amp_act));
        end
        if (pwr_act !== pwr_exp) begin
            fail_now($sformatf("FAILED t=%0t pwr_enable expected=%b actual=%b",
                               $time, pwr_exp, pwr_act));
        end
    endtask

    // cycle count, timeout, read return and enable compare
    always @(posedge sysclk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            fail_now("timeout: the test did not finish within the cycle limit");
        end else if (checking) begin
            if (reg_rvalid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    fail_now("reg_rvalid pulsed with no read outstanding");
                end else if (cyc - issue_q[0] != READ_LATENCY) begin
                    fail_now($sformatf("reg_rvalid came %0d cycles after its read strobe",
                                       cyc - issue_q[0]));
                end else begin
                    compare_word("reg_rdata", reg_rdata, exp_q.pop_front());
                    void'(issue_q.pop_front());
                end
            end else if (reg_rvalid !== 1'b0) begin
                fail_now("reg_rvalid is unknown");
            end
            // enables only once the last change has had time to land
            if (cyc >= settle_until) begin
                compare_enable(amp_enable, expect_amp(), pwr_enable, m_pwr);
            end
        end
    end

    // --------------------
    // stimulus
    // --------------------
    task automatic next_cycle();
        @(posedge sysclk);
        #5;
    endtask

    task automatic bus_write(logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] data);
        reg_wen      = 1'b1;
        reg_waddr    = addr;
        reg_wdata    = data;
        settle_until = cyc + 3;
        next_cycle();
        reg_wen = 1'b0;
    endtask

    // expected word taken at issue since nothing changes while it is in flight
    task automatic bus_read(logic [ADDR_W-1:0] addr);
        reg_ren   = 1'b1;
        reg_raddr = addr;
        exp_q.push_back(expect_word(addr));
        issue_q.push_back(cyc);
        next_cycle();
        reg_ren = 1'b0;
    endtask

    task automatic drain_reads();
        while (exp_q.size() != 0) begin
            next_cycle();
        end
    endtask

    // command lands two cycles after the strobe
    task automatic write_cmd(int a, logic signed [CUR_W-1:0] v);
        reg_word_t               w;
        logic signed [CUR_W-1:0] old;
        w         = $random(seed);
        w.dac.cur = v;
        old       = m_cmd[a];
        m_cmd[a]  = v;
        bus_write(reg_addr(a + 1, OFF_DAC_CMD), w);
        compare_cur($sformatf("cur_cmd[%0d]", a), cur_cmd[a], old);
        next_cycle();
        compare_cur($sformatf("cur_cmd[%0d]", a), cur_cmd[a], v);
    endtask

    // read-only fields of the word are ignored
    task automatic write_ctrl(reg_word_t w);
        m_mask = w.ctrl.amp_mask;
        m_pwr  = w.ctrl.pwr_en;
        bus_write(reg_addr(0, OFF_BOARD_CTRL), w);
    endtask

    // rearm lands before the next adc sample can
    task automatic clear_trip(int a);
        m_trip[a] = 1'b0;
        m_cnt[a]  = 0;
        bus_write(reg_addr(a + 1, OFF_SAFETY), $random(seed));
        next_cycle();
    endtask

    // one adc strobe for all axes at once
    task automatic drive_sample();
        for (int a = 0; a < NUM_AXES; a++) begin
            cur_fb[a] = next_fb[a];
            m_fb[a]   = next_fb[a];
            if (!over_limit(next_fb[a], m_cmd[a])) begin
                m_cnt[a] = 0;
            end else if (m_cnt[a] < SAFETY_COUNT) begin
                m_cnt[a]++;
            end
            if (m_cnt[a] == SAFETY_COUNT) begin
                m_trip[a] = 1'b1;
            end
        end
        adc_valid    = 1'b1;
        settle_until = cyc + 3;
        next_cycle();
        adc_valid = 1'b0;
    endtask

    // odd axes get the negative value
    task automatic set_fb(int v);
        for (int a = 0; a < NUM_AXES; a++) begin
            next_fb[a] = CUR_W'((a % 2) ? -v : v);
        end
    endtask

    // board words and every axis register back to back
    task automatic read_all();
        repeat (3) next_cycle();
        bus_read(reg_addr(0, OFF_BOARD_CTRL));
        bus_read(reg_addr(0, OFF_BOARD_ID));
        for (int a = 1; a <= NUM_AXES; a++) begin
            for (int o = 0; o < 3; o++) begin
                bus_read(reg_addr(a, o));
            end
        end
        drain_reads();
    endtask

    initial begin
        reg_word_t ctrl_w;
        seed         = 32'ha0e488d2;
        cyc          = 0;
        settle_until = 0;
        checking     = 1'b0;
        rst_n        = 1'b0;
        reg_wen      = 1'b0;
        reg_waddr    = '0;
        reg_wdata    = '0;
        reg_ren      = 1'b0;
        reg_raddr    = '0;
        cur_fb       = '0;
        adc_valid    = 1'b0;
        board_id     = BOARD_ID;
        m_trip       = '0;
        m_mask       = '0;
        m_pwr        = 1'b0;
        for (int a = 0; a < NUM_AXES; a++) begin
            m_cmd[a]   = '0;
            m_fb[a]    = '0;
            next_fb[a] = '0;
            m_cnt[a]   = 0;
        end
        repeat (10) @(posedge sysclk);
        #5;
        rst_n = 1'b1;

        // reset state
        if (reg_rvalid !== 1'b0) begin
            fail_now("reg_rvalid is not low after reset");
        end
        compare_enable(amp_enable, expect_amp(), pwr_enable, m_pwr);
        checking = 1'b1;
        read_all();

        // -------------------- command writes and readback
        for (int a = 0; a < NUM_AXES; a++) begin
            repeat (4) write_cmd(a, CUR_W'($random(seed)));
        end
        write_cmd(1, 16'sh8000);
        // unmapped channel that nobody takes
        bus_write(reg_addr(9, OFF_DAC_CMD), $random(seed));
        for (int a = 1; a <= NUM_AXES; a++) begin
            bus_read(reg_addr(a, OFF_DAC_CMD));
        end
        for (int c = NUM_AXES + 1; c < 16; c++) begin
            bus_read(reg_addr(c, c % 3));
        end
        bus_read(reg_addr(2, 7));
        bus_read(reg_addr(0, 2));
        drain_reads();

        // -------------------- board control
        repeat (6) begin
            write_ctrl($random(seed));
            read_all();
        end
        ctrl_w               = '0;
        ctrl_w.ctrl.amp_mask = '1;
        ctrl_w.ctrl.pwr_en   = 1'b1;
        write_ctrl(ctrl_w);
        read_all();

        // -------------------- random feedback, trips
        repeat (4) begin
            for (int a = 0; a < NUM_AXES; a++) begin
                write_cmd(a, CUR_W'($random(seed) % 2000));
                clear_trip(a);
            end
            repeat (30) begin
                for (int a = 0; a < NUM_AXES; a++) begin
                    next_fb[a] = random_fb(m_cmd[a]);
                end
                drive_sample();
            end
            read_all();
        end

        // -------------------- clear and run restart
        for (int a = 0; a < NUM_AXES; a++) begin
            write_cmd(a, 16'sd100);
            clear_trip(a);
        end
        read_all();
        // at exactly twice the command is still inside
        for (int n = 0; n < 3; n++) begin
            set_fb(300 + n);
            drive_sample();
        end
        set_fb(200);
        drive_sample();
        for (int n = 0; n < 3; n++) begin
            set_fb(201 + n);
            drive_sample();
        end
        read_all();
        set_fb(32768);
        drive_sample();
        read_all();
        for (int a = 0; a < NUM_AXES; a++) begin
            clear_trip(a);
        end
        read_all();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: motor_ctrl_top.f
qla_pkg.sv
reg_bus_if.sv
reg_decoder.sv
axis_channel.sv
board_regs.sv
motor_ctrl_top.sv
tb_clkgen.sv
motor_ctrl_tb.sv
